// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - common/rvPkg.sv
  - datapath/rvRegFile.sv
  - datapath/rvAlu.sv
  - datapath/rvLoadStore.sv
  - datapath/rvDatapath.sv
  - control/rvControl.sv
  - source/rvCore.sv
  - target: test
    files:
      - test/rvCore_chk.sv
      - test/rvCoreTb.sv

// ==== common/rvPkg.sv ====
// width constants and the opcode, phase, ALU and datapath mux select enums
package rvPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// ~~~~~~~~~~~~~~~~~~~~
	// major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		OP_IMM   = 7'b0010011,
		OP       = 7'b0110011,
		MISC_MEM = 7'b0001111
	} opcodeT;

	// execution phases of the multicycle FSM
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		MERGE,
		MEMWRITE,
		WRITEBACK,
		HALT
	} phaseT;

	// encoded as {bit 30, funct3}
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b1000,
		SLL  = 4'b0001,
		SLT  = 4'b0010,
		SLTU = 4'b0011,
		XOR  = 4'b0100,
		SRL  = 4'b0101,
		SRA  = 4'b1101,
		OR   = 4'b0110,
		AND  = 4'b0111
	} aluOpT;

	// ~~~~~~~~~~~~~~~~~~~~
	// datapath mux selects
	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pcSelT;
	typedef enum logic [1:0] {ADDR_PC, ADDR_ALU, ADDR_MAR} addrSelT;
	typedef enum logic {A_REG, A_PC} aluASelT;
	typedef enum logic {B_REG, B_IMM} aluBSelT;

	typedef enum logic [2:0] {
		REG_ALU,
		REG_IMM,
		REG_PC,
		REG_LOAD_BYTE,
		REG_LOAD_HALF,
		REG_LOAD_WORD
	} regSelT;

	typedef enum logic [1:0] {STORE_BYTE, STORE_HALF, STORE_WORD} storeSelT;

endpackage

// ==== control/rvControl.sv ====
// rvControl, phase FSM with instruction decode, datapath selects and memory strobes
`timescale 1ns/1ps

module rvControl import rvPkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            ready,
	input  logic [XLEN-1:0] instr,
	input  logic            aluOutNonzero,
	output logic            rd,
	output logic            we,
	output logic            pcWrite,
	output pcSelT           pcSel,
	output addrSelT         addrSel,
	output logic            irWrite,
	output aluOpT           aluOp,
	output aluASelT         aluASel,
	output aluBSelT         aluBSel,
	output logic            regWrite,
	output regSelT          regSel,
	output storeSelT        storeSel
);

	phaseT phase, phaseNext;
	opcodeT opcode;
	logic [2:0] funct3;
	logic bit30;
	logic firstCycle;
	logic strobe;
	logic branchTaken;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign bit30 = instr[30];

	// ~~~~~~~~~~~~~~~~~~~~
	// memory fuse, strobe only on the first cycle of a phase
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= FETCH;
			firstCycle <= 1'b1;
		end else begin
			phase <= phaseNext;
			firstCycle <= (phaseNext != phase);
		end
	end

	// the bus stays quiet while reset is held
	assign strobe = firstCycle & ~rst;

	// BGE, BGEU and BEQ invert the sense of the compare result
	assign branchTaken = (funct3[2] ? funct3[0] : ~funct3[0]) ^ aluOutNonzero;

	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		phaseNext = phase;
		rd = 1'b0;
		we = 1'b0;
		pcWrite = 1'b0;
		pcSel = PC_PLUS4;
		addrSel = ADDR_PC;
		irWrite = 1'b0;
		aluOp = ADD;
		aluASel = A_REG;
		aluBSel = B_REG;
		regWrite = 1'b0;
		regSel = REG_ALU;
		storeSel = STORE_WORD;
		case (phase)
			FETCH: begin
				rd = strobe;
				irWrite = ready;
				if (ready) phaseNext = DECODE;
			end
			DECODE: begin
				// pc + imm for AUIPC, JAL and branch targets
				aluASel = A_PC;
				aluBSel = B_IMM;
				pcWrite = 1'b1;
				case (opcode)
					LUI, AUIPC, JAL: phaseNext = WRITEBACK;
					MISC_MEM: phaseNext = FETCH;
					JALR, BRANCH, LOAD, STORE, OP_IMM, OP: phaseNext = EXECUTE;
					default: begin
						pcWrite = 1'b0;
						phaseNext = HALT;
					end
				endcase
			end
			EXECUTE: begin
				phaseNext = (opcode == LOAD || opcode == STORE) ? MEMORY : WRITEBACK;
				case (opcode)
					OP: aluOp = aluOpT'({bit30, funct3});
					OP_IMM: begin
						// bit 30 only selects SRAI
						aluOp = aluOpT'({bit30 & (funct3 == 3'b101), funct3});
						aluBSel = B_IMM;
					end
					BRANCH: aluOp = funct3[2] ? aluOpT'({2'b00, funct3[2:1]}) : SUB;
					default: aluBSel = B_IMM;
				endcase
			end
			MEMORY: begin
				// address recomputed each cycle so aluOut stays put
				aluBSel = B_IMM;
				addrSel = ADDR_ALU;
				if (opcode == STORE && !funct3[1]) begin
					rd = strobe;
				end else if (opcode == STORE) begin
					we = strobe;
				end else begin
					rd = strobe;
				end
				if (ready) begin
					if (opcode == LOAD) phaseNext = WRITEBACK;
					else if (!funct3[1]) phaseNext = MERGE;
					else phaseNext = FETCH;
				end
			end
			MERGE: begin
				addrSel = ADDR_MAR;
				phaseNext = MEMWRITE;
			end
			MEMWRITE: begin
				addrSel = ADDR_MAR;
				storeSel = funct3[0] ? STORE_HALF : STORE_BYTE;
				we = strobe;
				if (ready) phaseNext = FETCH;
			end
			WRITEBACK: begin
				phaseNext = FETCH;
				regWrite = 1'b1;
				case (opcode)
					LUI: regSel = REG_IMM;
					JAL: begin
						regSel = REG_PC;
						pcWrite = 1'b1;
						pcSel = PC_JAL;
					end
					JALR: begin
						regSel = REG_PC;
						pcWrite = 1'b1;
						pcSel = PC_JALR;
					end
					BRANCH: begin
						regWrite = 1'b0;
						pcWrite = branchTaken;
						pcSel = PC_BRANCH;
					end
					LOAD: begin
						case (funct3[1:0])
							2'b00: regSel = REG_LOAD_BYTE;
							2'b01: regSel = REG_LOAD_HALF;
							default: regSel = REG_LOAD_WORD;
						endcase
					end
					default: regSel = REG_ALU;
				endcase
			end
			default: begin
				// halted, left only through reset
				phaseNext = HALT;
			end
		endcase
	end

endmodule

// ==== datapath/rvAlu.sv ====
// rvAlu, combinational ALU for the RV32I integer operations
`timescale 1ns/1ps

module rvAlu import rvPkg::*; (
	input  aluOpT           op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] y
);

	logic [4:0] shamt;

	// shifts use the low 5 bits only
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ADD:  y = a + b;
			SUB:  y = a - b;
			SLL:  y = a << shamt;
			SLT:  y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU: y = {{(XLEN-1){1'b0}}, a < b};
			XOR:  y = a ^ b;
			SRL:  y = a >> shamt;
			SRA:  y = $unsigned($signed(a) >>> shamt);
			OR:   y = a | b;
			AND:  y = a & b;
			default: y = '0;
		endcase
	end

endmodule

// ==== datapath/rvDatapath.sv ====
// PC, IR, operand, ALU and memory registers with immediate generation and datapath muxes
`timescale 1ns/1ps

module rvDatapath import rvPkg::*; #(
	parameter logic [XLEN-1:0] resetAddr = 32'h00000000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            pcWrite,
	input  pcSelT           pcSel,
	input  addrSelT         addrSel,
	input  logic            irWrite,
	input  aluOpT           aluOp,
	input  aluASelT         aluASel,
	input  aluBSelT         aluBSel,
	input  logic            regWrite,
	input  regSelT          regSel,
	input  storeSelT        storeSel,
	input  logic [XLEN-1:0] rdata,
	output logic [XLEN-1:0] instr,
	output logic            aluOutNonzero,
	output logic [XLEN-1:0] addr,
	output logic [XLEN-1:0] wdata
);

	logic [XLEN-1:0] pc, nextPc;
	logic [XLEN-1:0] regA, regB, rs1Data, rs2Data;
	logic [XLEN-1:0] aluA, aluB, aluY, aluOut, aluOut2;
	logic [XLEN-1:0] mar, mdr, memAddr, storeData, rdataLe;
	logic [XLEN-1:0] imm, regWdata;
	logic [XLEN-1:0] loadByte, loadHalf, storeByte, storeHalf;
	opcodeT opcode;

	// bus words are byte reversed against the register value
	function automatic logic [XLEN-1:0] swapBytes(input logic [XLEN-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign rdataLe = swapBytes(rdata);
	assign wdata = swapBytes(storeData);
	// bus addresses are always word aligned
	assign addr = {memAddr[XLEN-1:2], 2'b00};

	// ~~~~~~~~~~~~~~~~~~~~
	// program counter
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetAddr;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (irWrite) begin
			instr <= rdataLe;
		end
		regA <= rs1Data;
		regB <= rs2Data;
		aluOut <= aluY;
		// branch target computed in DECODE is one cycle older
		aluOut2 <= aluOut;
		// held through MERGE and MEMWRITE of a sub-word store
		if (addrSel != ADDR_MAR) begin
			mar <= memAddr;
			mdr <= rdataLe;
		end
	end

	always_comb begin
		case (pcSel)
			PC_BRANCH: nextPc = aluOut2;
			PC_JAL:    nextPc = aluOut;
			PC_JALR:   nextPc = aluOut & ~32'd1;
			default:   nextPc = pc + 32'd4;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// immediates by instruction format
	assign opcode = opcodeT'(instr[6:0]);

	always_comb begin
		case (opcode)
			LUI, AUIPC: imm = {instr[31:12], 12'b0};
			JAL:        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			BRANCH:     imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			STORE:      imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			default:    imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	rvRegFile i_regFile (
		.clk(clk),
		.raddr0(instr[19:15]),
		.raddr1(instr[24:20]),
		.waddr(instr[11:7]),
		.we(regWrite),
		.wdata(regWdata),
		.rdata0(rs1Data),
		.rdata1(rs2Data)
	);

	assign aluA = (aluASel == A_PC) ? pc : regA;
	assign aluB = (aluBSel == B_IMM) ? imm : regB;

	rvAlu i_alu (
		.op(aluOp),
		.a(aluA),
		.b(aluB),
		.y(aluY)
	);

	assign aluOutNonzero = |aluOut;

	rvLoadStore i_loadStore (
		.mdr(mdr),
		.byteOffset(mar[1:0]),
		.storeValue(rs2Data),
		.unsignedLoad(instr[14]),
		.loadByte(loadByte),
		.loadHalf(loadHalf),
		.storeByte(storeByte),
		.storeHalf(storeHalf)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (addrSel)
			ADDR_ALU: memAddr = aluOut;
			ADDR_MAR: memAddr = mar;
			default:  memAddr = pc;
		endcase
	end

	always_comb begin
		case (storeSel)
			STORE_BYTE: storeData = storeByte;
			STORE_HALF: storeData = storeHalf;
			default:    storeData = rs2Data;
		endcase
	end

	// pc is already advanced when WRITEBACK uses it as link value
	always_comb begin
		case (regSel)
			REG_IMM:       regWdata = imm;
			REG_PC:        regWdata = pc;
			REG_LOAD_BYTE: regWdata = loadByte;
			REG_LOAD_HALF: regWdata = loadHalf;
			REG_LOAD_WORD: regWdata = mdr;
			default:       regWdata = aluOut;
		endcase
	end

endmodule

// ==== datapath/rvLoadStore.sv ====
// rvLoadStore, load lane select with extension and sub-word store merge
`timescale 1ns/1ps

module rvLoadStore import rvPkg::*; (
	input  logic [XLEN-1:0] mdr,
	input  logic [1:0]      byteOffset,
	input  logic [XLEN-1:0] storeValue,
	input  logic            unsignedLoad,
	output logic [XLEN-1:0] loadByte,
	output logic [XLEN-1:0] loadHalf,
	output logic [XLEN-1:0] storeByte,
	output logic [XLEN-1:0] storeHalf
);

	logic [7:0]  byteLane;
	logic [15:0] halfLane;

	// ~~~~~~~~~~~~~~~~~~~~
	// byte lane, read and merged
	always_comb begin
		case (byteOffset)
			2'b00: begin
				byteLane = mdr[7:0];
				storeByte = {mdr[31:8], storeValue[7:0]};
			end
			2'b01: begin
				byteLane = mdr[15:8];
				storeByte = {mdr[31:16], storeValue[7:0], mdr[7:0]};
			end
			2'b10: begin
				byteLane = mdr[23:16];
				storeByte = {mdr[31:24], storeValue[7:0], mdr[15:0]};
			end
			default: begin
				byteLane = mdr[31:24];
				storeByte = {storeValue[7:0], mdr[23:0]};
			end
		endcase
	end

	// halfword lane, bit 0 of the offset is ignored
	always_comb begin
		if (byteOffset[1]) begin
			halfLane = mdr[31:16];
			storeHalf = {storeValue[15:0], mdr[15:0]};
		end else begin
			halfLane = mdr[15:0];
			storeHalf = {mdr[31:16], storeValue[15:0]};
		end
	end

	// sign or zero extension from funct3 bit 2
	assign loadByte = {{24{~unsignedLoad & byteLane[7]}}, byteLane};
	assign loadHalf = {{16{~unsignedLoad & halfLane[15]}}, halfLane};

endmodule

// ==== datapath/rvRegFile.sv ====
// rvRegFile, 32 x 32 register file with two read ports and x0 tied to zero
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
	input  logic                  clk,
	input  logic [REG_ADDR_W-1:0] raddr0,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic                  we,
	input  logic [XLEN-1:0]       wdata,
	output logic [XLEN-1:0]       rdata0,
	output logic [XLEN-1:0]       rdata1
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	// entry 0 is never written
	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads
	assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== project.f ====
common/rvPkg.sv
datapath/rvRegFile.sv
datapath/rvAlu.sv
datapath/rvLoadStore.sv
datapath/rvDatapath.sv
control/rvControl.sv
source/rvCore.sv
test/rvCore_chk.sv
test/rvCoreTb.sv

// ==== source/rvCore.sv ====
// rvCore, multicycle RV32I core joining the control FSM and the datapath
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
	parameter logic [XLEN-1:0] resetAddr = 32'h00000000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            ready,
	input  logic [XLEN-1:0] rdata,
	output logic [XLEN-1:0] addr,
	output logic [XLEN-1:0] wdata,
	output logic            rd,
	output logic            we
);

	// control to datapath
	logic     pcWrite;
	pcSelT    pcSel;
	addrSelT  addrSel;
	logic     irWrite;
	aluOpT    aluOp;
	aluASelT  aluASel;
	aluBSelT  aluBSel;
	logic     regWrite;
	regSelT   regSel;
	storeSelT storeSel;

	// datapath back to control
	logic [XLEN-1:0] instr;
	logic            aluOutNonzero;

	rvControl i_control (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.instr(instr),
		.aluOutNonzero(aluOutNonzero),
		.rd(rd),
		.we(we),
		.pcWrite(pcWrite),
		.pcSel(pcSel),
		.addrSel(addrSel),
		.irWrite(irWrite),
		.aluOp(aluOp),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.regWrite(regWrite),
		.regSel(regSel),
		.storeSel(storeSel)
	);

	rvDatapath #(
		.resetAddr(resetAddr)
	) i_datapath (
		.clk(clk),
		.rst(rst),
		.pcWrite(pcWrite),
		.pcSel(pcSel),
		.addrSel(addrSel),
		.irWrite(irWrite),
		.aluOp(aluOp),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.regWrite(regWrite),
		.regSel(regSel),
		.storeSel(storeSel),
		.rdata(rdata),
		.instr(instr),
		.aluOutNonzero(aluOutNonzero),
		.addr(addr),
		.wdata(wdata)
	);

endmodule

// ==== test/rvCoreTb.sv ====
// random program testbench with memory model, instruction-set model and checks
`timescale 1ns/1ps

module rvCoreTb;

	localparam logic [31:0] RESET_ADDR = 32'h00000000;
	localparam int NUM_RANDOM = 40;
	localparam int PREAMBLE = 14;
	localparam int HALT_SLOT = PREAMBLE + 2 * NUM_RANDOM;
	localparam logic [31:0] DATA_BASE = 32'h200;
	localparam logic [31:0] SCRATCH = 32'h300;
	// 20 cycles per instruction plus the quiet period after the halt
	localparam int CYCLE_LIMIT = (HALT_SLOT + 1) * 20 + 50;

	logic clk = 1'b0;
	logic rst, ready, rd, we;
	logic [31:0] rdata, addr, wdata;

	logic [31:0] mem [256];
	logic [31:0] modelMem [256];
	logic [31:0] x [32];
	bit expWrite [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	integer seed = 64;
	int cycleCount = 0;
	int pos;
	bit pending = 1'b0;
	bit pendWrite;
	int delay;
	logic [31:0] pendAddr, pendData;
	bit nextWrite;
	logic [31:0] nextAddr, nextData;

	rvCore #(
		.resetAddr(RESET_ADDR)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.rdata(rdata),
		.addr(addr),
		.wdata(wdata),
		.rd(rd),
		.we(we)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	function automatic int unsigned randBelow(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// bus words carry byte 0 of the value on bits 31:24
	function automatic logic [31:0] byteReverse(logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// instruction encoders
	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rdI, logic [6:0] op);
		return {imm, rs1, f3, rdI, op};
	endfunction

	function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rdI);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rdI, 7'h6f};
	endfunction

	task automatic put(input logic [31:0] word);
		mem[pos] = word;
		pos++;
	endtask

	// offset into the 64-word data window aligned to the access size
	function automatic int unsigned windowOffset(logic [1:0] size);
		if (size == 2'd0) return randBelow(256);
		else if (size == 2'd1) return 2 * randBelow(128);
		else return 4 * randBelow(64);
	endfunction

	task automatic genRandom();
		int unsigned branchF3 [6] = '{0, 1, 4, 5, 6, 7};
		int unsigned loadF3 [5] = '{0, 1, 2, 4, 5};
		int unsigned rdI, rs1, rs2, f3, imm, maxOff, off;
		logic [6:0] f7;
		rdI = 1 + randBelow(7);
		rs1 = 1 + randBelow(7);
		rs2 = 1 + randBelow(7);
		maxOff = (HALT_SLOT - pos < 3) ? HALT_SLOT - pos : 3;
		off = 1 + randBelow(maxOff);
		case (randBelow(10))
			0: put({20'(randBelow(32'h100000)), rdI[4:0], 7'h37});
			1: put({20'(randBelow(32'h100000)), rdI[4:0], 7'h17});
			2: put(encJ(4 * off, rdI));
			// absolute target through x0
			3: put(encI(RESET_ADDR + 4 * (pos + off), 5'd0, 3'd0, rdI, 7'h67));
			4: put(encB(4 * off, rs2, rs1, branchF3[randBelow(6)]));
			5: begin
				f3 = loadF3[randBelow(5)];
				put(encI(DATA_BASE + windowOffset(f3[1:0]), 5'd0, f3, rdI, 7'h03));
			end
			6: begin
				f3 = randBelow(3);
				put(encS(DATA_BASE + windowOffset(f3[1:0]), rs2, f3));
			end
			7: begin
				f3 = randBelow(8);
				if (f3 == 1) imm = randBelow(32);
				else if (f3 == 5) imm = randBelow(32) | (randBelow(2) << 10);
				else imm = randBelow(4096);
				put(encI(imm, rs1, f3, rdI, 7'h13));
			end
			8: begin
				f3 = randBelow(8);
				f7 = ((f3 == 0 || f3 == 5) && randBelow(2) == 1) ? 7'h20 : 7'h00;
				put({f7, rs2[4:0], rs1[4:0], f3[2:0], rdI[4:0], 7'h33});
			end
			default: put(32'h0000000f);
		endcase
		put(encS(SCRATCH, rdI, 3'd2));
	endtask

	task automatic buildProgram();
		for (int i = 0; i < 256; i++) begin
			mem[i] = i * 32'h9e3779b1 + 32'h01234567;
		end
		pos = RESET_ADDR[9:2];
		// give x1 to x7 defined random values
		for (int r = 1; r < 8; r++) begin
			put({20'(randBelow(32'h100000)), r[4:0], 7'h37});
			put(encI(randBelow(4096), r, 3'd0, r, 7'h13));
		end
		for (int k = 0; k < NUM_RANDOM; k++) begin
			genRandom();
		end
		// custom-0 opcode outside the supported set
		put(32'h0000000b);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// instruction-set model building the expected bus accesses
	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) return $signed(a) >>> b[4:0];
				else return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic expectAccess(input bit isWrite, input logic [31:0] a, input logic [31:0] d);
		expWrite.push_back(isWrite);
		expAddr.push_back({a[31:2], 2'b00});
		expData.push_back(d);
	endtask

	task automatic runModel();
		logic [31:0] pc, npc, ins, a, b, w, lane, mask, v;
		logic [31:0] immI, immS, immB, immJ;
		bit taken, running, writeRd;
		for (int i = 0; i < 32; i++) x[i] = '0;
		pc = RESET_ADDR;
		running = 1'b1;
		while (running) begin
			expectAccess(1'b0, pc, '0);
			ins = modelMem[pc[9:2]];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			npc = pc + 4;
			writeRd = 1'b1;
			case (ins[6:0])
				7'h37: v = {ins[31:12], 12'b0};
				7'h17: v = pc + {ins[31:12], 12'b0};
				7'h6f: begin
					v = pc + 4;
					npc = pc + immJ;
				end
				7'h67: begin
					v = pc + 4;
					npc = (a + immI) & ~32'd1;
				end
				7'h63: begin
					writeRd = 1'b0;
					case (ins[14:12])
						3'd0: taken = (a == b);
						3'd1: taken = (a != b);
						3'd4: taken = ($signed(a) < $signed(b));
						3'd5: taken = ($signed(a) >= $signed(b));
						3'd6: taken = (a < b);
						default: taken = (a >= b);
					endcase
					if (taken) npc = pc + immB;
				end
				7'h03: begin
					a = a + immI;
					expectAccess(1'b0, a, '0);
					w = modelMem[a[9:2]];
					lane = w >> (8 * a[1:0]);
					case (ins[14:12])
						3'd0: v = {{24{lane[7]}}, lane[7:0]};
						3'd1: v = {{16{lane[15]}}, lane[15:0]};
						3'd4: v = {24'b0, lane[7:0]};
						3'd5: v = {16'b0, lane[15:0]};
						default: v = w;
					endcase
				end
				7'h23: begin
					writeRd = 1'b0;
					a = a + immS;
					w = modelMem[a[9:2]];
					if (ins[14:12] == 3'd2) begin
						w = b;
					end else begin
						// sub-word store reads the word first
						expectAccess(1'b0, a, '0);
						mask = (ins[12] ? 32'hffff : 32'hff) << (8 * a[1:0]);
						w = (w & ~mask) | ((b << (8 * a[1:0])) & mask);
					end
					modelMem[a[9:2]] = w;
					expectAccess(1'b1, a, w);
				end
				7'h13: v = aluRef(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
				7'h33: v = aluRef(ins[14:12], ins[30], a, b);
				7'h0f: writeRd = 1'b0;
				default: begin
					writeRd = 1'b0;
					running = 1'b0;
				end
			endcase
			if (writeRd && ins[11:7] != 5'd0) x[ins[11:7]] = v;
			pc = npc;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// strobes sampled at the rising edge
	always @(posedge clk) begin
		if (rst) begin
			if (rd || we) begin
				$display("memory strobe raised while reset was held");
				$display("Checks failed");
				$fatal(1, "strobe during reset");
			end
		end else if (rd || we) begin
			if (expAddr.size() == 0) begin
				$display("unexpected bus access to address %h after the program ended", addr);
				$display("Checks failed");
				$fatal(1, "unexpected bus access");
			end else begin
				nextWrite = expWrite.pop_front();
				nextAddr = expAddr.pop_front();
				nextData = expData.pop_front();
				checkValue({31'b0, we}, {31'b0, nextWrite}, "access kind");
				checkValue(addr, nextAddr, "address");
				if (we) checkValue(byteReverse(wdata), nextData, "write data");
				pending = 1'b1;
				delay = 1 + randBelow(4);
				pendWrite = we;
				pendAddr = addr;
				pendData = wdata;
			end
		end
	end

	// memory answer driven on the falling edge
	always @(negedge clk) begin
		ready = 1'b0;
		rdata = $random(seed);
		if (pending) begin
			delay--;
			if (delay == 0) begin
				ready = 1'b1;
				pending = 1'b0;
				if (pendWrite) mem[pendAddr[9:2]] = byteReverse(pendData);
				else rdata = byteReverse(mem[pendAddr[9:2]]);
			end
		end
	end

	// a failed assertion in the bound checker ends the run
	always @(posedge clk) begin
		if (i_dut.i_chk.failCount != 0) begin
			$display("a bus protocol assertion failed in the bound checker");
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the core stopped making progress", cycleCount);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst = 1'b1;
		ready = 1'b0;
		rdata = '0;
		buildProgram();
		modelMem = mem;
		runModel();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		while (expAddr.size() != 0 || pending) @(posedge clk);
		// halted core stays off the bus
		repeat (50) @(negedge clk);
		if (i_dut.i_chk.failCount == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "bus checker assertions failed");
		end
	end

endmodule

// ==== test/rvCore_chk.sv ====
// bound assertions on the memory strobes and the bus hold of rvCore
`timescale 1ns/1ps

module rvCoreChk (
	input logic        clk,
	input logic        rst,
	input logic        rd,
	input logic        we,
	input logic        ready,
	input logic [31:0] addr,
	input logic [31:0] wdata
);

	int failCount = 0;
	logic outstanding;

	// set by a strobe and cleared by the answering ready
	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (ready) begin
			outstanding <= 1'b0;
		end else if (rd || we) begin
			outstanding <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	strobeExclusive: assert property (@(posedge clk) disable iff (rst) !(rd && we))
		else begin
			$error("rd and we are high in the same cycle");
			failCount++;
		end

	strobeOneCycle: assert property (@(posedge clk) disable iff (rst)
		(rd || we) |=> !(rd || we))
		else begin
			$error("memory strobe lasts longer than one cycle");
			failCount++;
		end

	strobeAfterReady: assert property (@(posedge clk) disable iff (rst)
		(rd || we) |-> !outstanding)
		else begin
			$error("new memory strobe before ready of the previous one");
			failCount++;
		end

	// address and write data stay put from the strobe up to the ready cycle
	busHeld: assert property (@(posedge clk) disable iff (rst)
		outstanding |-> ($stable(addr) && $stable(wdata)))
		else begin
			$error("address or write data changed before ready");
			failCount++;
		end

endmodule

bind rvCore rvCoreChk i_chk (
	.clk(clk),
	.rst(rst),
	.rd(rd),
	.we(we),
	.ready(ready),
	.addr(addr),
	.wdata(wdata)
);
